//--- tb.f
+incdir+logic
+incdir+testbench
logic/fp_dec_pkg.sv
logic/fp_ext_cfg.sv
logic/fp_insn_classify.sv
logic/fp_decode_stage.sv
logic/fp_decoder_top.sv
testbench/tb_fp_decoder.sv

//--- run_sim.sh
#!/bin/sh
# build and run the decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module tb_fp_decoder -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test passed"; then
  exit 0
fi
exit 1

//--- testbench/tb_fp_vectors.svh
`ifndef TB_FP_VECTORS_SVH
`define TB_FP_VECTORS_SVH

// columns: name, level, word, random regs {rs3, rs2},
// operation, modifier, format, load, illegal, rounding mode, dynamic
task automatic load_vectors();
  ////////////////////////////////////////
  // fused multiply-add
  ////////////////////////////////////////
  add_vec("fmadd_s", EXT_DOUBLE, enc_r4(OPC_MADD, 2'b00, 3'b000), 2'b11,
          OP_FMADD, 1'b0, FMT_FP32, 1'b0, 1'b0, RM_RNE, 1'b0);
  add_vec("fmsub_d", EXT_DOUBLE, enc_r4(OPC_MSUB, 2'b01, 3'b001), 2'b11,
          OP_FMADD, 1'b1, FMT_FP64, 1'b0, 1'b0, RM_RTZ, 1'b0);
  add_vec("fnmsub_s", EXT_DOUBLE, enc_r4(OPC_NMSUB, 2'b00, 3'b010), 2'b11,
          OP_FNMSUB, 1'b0, FMT_FP32, 1'b0, 1'b0, RM_RDN, 1'b0);
  add_vec("fnmadd_d_dyn", EXT_DOUBLE, enc_r4(OPC_NMADD, 2'b01, 3'b111), 2'b11,
          OP_FNMSUB, 1'b1, FMT_FP64, 1'b0, 1'b0, RM_DYN, 1'b1);
  add_vec("fmadd_bad_fmt", EXT_DOUBLE, enc_r4(OPC_MADD, 2'b10, 3'b000), 2'b11,
          OP_FMADD, 1'b0, FMT_FP32, 1'b0, 1'b1, RM_RNE, 1'b0);
  add_vec("fmadd_rm101", EXT_DOUBLE, enc_r4(OPC_MADD, 2'b00, 3'b101), 2'b11,
          OP_FMADD, 1'b0, FMT_FP32, 1'b0, 1'b1, fp_rm_e'(3'b101), 1'b0);
  ////////////////////////////////////////
  // op-fp arithmetic and friends
  ////////////////////////////////////////
  add_vec("fadd_s", EXT_DOUBLE, enc_op(7'b0000000, 5'd0, 3'b011), 2'b01,
          OP_ADD, 1'b0, FMT_FP32, 1'b0, 1'b0, RM_RUP, 1'b0);
  add_vec("fsub_d", EXT_DOUBLE, enc_op(7'b0000101, 5'd0, 3'b100), 2'b01,
          OP_ADD, 1'b1, FMT_FP64, 1'b0, 1'b0, RM_RMM, 1'b0);
  add_vec("fmul_s", EXT_DOUBLE, enc_op(7'b0001000, 5'd0, 3'b000), 2'b01,
          OP_MUL, 1'b0, FMT_FP32, 1'b0, 1'b0, RM_RNE, 1'b0);
  add_vec("fdiv_d_dyn", EXT_DOUBLE, enc_op(7'b0001101, 5'd0, 3'b111), 2'b01,
          OP_DIV, 1'b0, FMT_FP64, 1'b0, 1'b0, RM_DYN, 1'b1);
  add_vec("fsqrt_s", EXT_DOUBLE, enc_op(7'b0101100, 5'd0, 3'b000), 2'b00,
          OP_SQRT, 1'b0, FMT_FP32, 1'b0, 1'b0, RM_RNE, 1'b0);
  add_vec("fsqrt_bad_rs2", EXT_DOUBLE, enc_op(7'b0101100, 5'd1, 3'b000), 2'b00,
          OP_FMADD, 1'b0, FMT_FP32, 1'b0, 1'b1, RM_RNE, 1'b0);
  add_vec("fsgnjx_d", EXT_DOUBLE, enc_op(7'b0010001, 5'd0, 3'b010), 2'b01,
          OP_SGNJ, 1'b0, FMT_FP64, 1'b0, 1'b0, RM_RDN, 1'b0);
  add_vec("fsgnj_bad_f3", EXT_DOUBLE, enc_op(7'b0010000, 5'd0, 3'b011), 2'b01,
          OP_FMADD, 1'b0, FMT_FP32, 1'b0, 1'b1, RM_RUP, 1'b0);
  add_vec("fmax_s", EXT_DOUBLE, enc_op(7'b0010100, 5'd0, 3'b001), 2'b01,
          OP_MINMAX, 1'b0, FMT_FP32, 1'b0, 1'b0, RM_RTZ, 1'b0);
  add_vec("fmin_d", EXT_DOUBLE, enc_op(7'b0010101, 5'd0, 3'b000), 2'b01,
          OP_MINMAX, 1'b0, FMT_FP64, 1'b0, 1'b0, RM_RNE, 1'b0);
  add_vec("feq_d", EXT_DOUBLE, enc_op(7'b1010001, 5'd0, 3'b010), 2'b01,
          OP_CMP, 1'b0, FMT_FP64, 1'b0, 1'b0, RM_RDN, 1'b0);
  add_vec("flt_s", EXT_DOUBLE, enc_op(7'b1010000, 5'd0, 3'b001), 2'b01,
          OP_CMP, 1'b0, FMT_FP32, 1'b0, 1'b0, RM_RTZ, 1'b0);
  add_vec("fclass_d", EXT_DOUBLE, enc_op(7'b1110001, 5'd0, 3'b001), 2'b00,
          OP_CLASSIFY, 1'b0, FMT_FP64, 1'b0, 1'b0, RM_RTZ, 1'b0);
  ////////////////////////////////////////
  // conversions and moves
  ////////////////////////////////////////
  add_vec("fcvt_w_s", EXT_DOUBLE, enc_op(7'b1100000, 5'd0, 3'b001), 2'b00,
          OP_F2I, 1'b0, FMT_FP32, 1'b0, 1'b0, RM_RTZ, 1'b0);
  add_vec("fcvt_wu_d", EXT_DOUBLE, enc_op(7'b1100001, 5'd1, 3'b000), 2'b00,
          OP_F2I, 1'b1, FMT_FP64, 1'b0, 1'b0, RM_RNE, 1'b0);
  add_vec("fcvt_s_wu", EXT_DOUBLE, enc_op(7'b1101000, 5'd1, 3'b111), 2'b00,
          OP_I2F, 1'b1, FMT_FP32, 1'b0, 1'b0, RM_DYN, 1'b1);
  add_vec("fcvt_d_w", EXT_DOUBLE, enc_op(7'b1101001, 5'd0, 3'b000), 2'b00,
          OP_I2F, 1'b0, FMT_FP64, 1'b0, 1'b0, RM_RNE, 1'b0);
  add_vec("fcvt_bad_rs2", EXT_DOUBLE, enc_op(7'b1100000, 5'd2, 3'b000), 2'b00,
          OP_FMADD, 1'b0, FMT_FP32, 1'b0, 1'b1, RM_RNE, 1'b0);
  add_vec("fcvt_s_d", EXT_DOUBLE, enc_op(7'b0100000, 5'd1, 3'b000), 2'b00,
          OP_F2F, 1'b0, FMT_FP64, 1'b0, 1'b0, RM_RNE, 1'b0);
  add_vec("fcvt_d_s", EXT_DOUBLE, enc_op(7'b0100001, 5'd0, 3'b000), 2'b00,
          OP_F2F, 1'b0, FMT_FP64, 1'b0, 1'b0, RM_RNE, 1'b0);
  add_vec("fmv_x_w", EXT_DOUBLE, enc_op(7'b1110000, 5'd0, 3'b000), 2'b00,
          OP_ADD, 1'b0, FMT_FP32, 1'b0, 1'b0, RM_RNE, 1'b0);
  add_vec("fmv_w_x", EXT_DOUBLE, enc_op(7'b1111000, 5'd0, 3'b000), 2'b00,
          OP_ADD, 1'b0, FMT_FP32, 1'b0, 1'b0, RM_RNE, 1'b0);
  add_vec("fadd_rm101", EXT_DOUBLE, enc_op(7'b0000000, 5'd0, 3'b101), 2'b01,
          OP_FMADD, 1'b0, FMT_FP32, 1'b0, 1'b1, fp_rm_e'(3'b101), 1'b0);
  add_vec("fmul_rm110", EXT_DOUBLE, enc_op(7'b0001000, 5'd0, 3'b110), 2'b01,
          OP_FMADD, 1'b0, FMT_FP32, 1'b0, 1'b1, fp_rm_e'(3'b110), 1'b0);
  ////////////////////////////////////////
  // loads, stores, levels, unknowns
  ////////////////////////////////////////
  add_vec("flw", EXT_DOUBLE, enc_mem(OPC_LOAD_FP, 3'b010), 2'b01,
          OP_FMADD, 1'b0, FMT_FP32, 1'b1, 1'b0, RM_RDN, 1'b0);
  add_vec("fld", EXT_DOUBLE, enc_mem(OPC_LOAD_FP, 3'b011), 2'b01,
          OP_FMADD, 1'b0, FMT_FP64, 1'b1, 1'b0, RM_RUP, 1'b0);
  add_vec("fsw", EXT_DOUBLE, enc_mem(OPC_STORE_FP, 3'b010), 2'b01,
          OP_FMADD, 1'b0, FMT_FP32, 1'b0, 1'b0, RM_RDN, 1'b0);
  add_vec("fsd", EXT_DOUBLE, enc_mem(OPC_STORE_FP, 3'b011), 2'b01,
          OP_FMADD, 1'b0, FMT_FP64, 1'b0, 1'b0, RM_RUP, 1'b0);
  add_vec("flw_bad_f3", EXT_DOUBLE, enc_mem(OPC_LOAD_FP, 3'b001), 2'b01,
          OP_FMADD, 1'b0, FMT_FP32, 1'b0, 1'b1, RM_RTZ, 1'b0);
  add_vec("single_fadd_s", EXT_SINGLE, enc_op(7'b0000000, 5'd0, 3'b000), 2'b01,
          OP_ADD, 1'b0, FMT_FP32, 1'b0, 1'b0, RM_RNE, 1'b0);
  add_vec("single_fadd_d", EXT_SINGLE, enc_op(7'b0000001, 5'd0, 3'b000), 2'b01,
          OP_FMADD, 1'b0, FMT_FP64, 1'b0, 1'b1, RM_RNE, 1'b0);
  add_vec("single_fld", EXT_SINGLE, enc_mem(OPC_LOAD_FP, 3'b011), 2'b01,
          OP_FMADD, 1'b0, FMT_FP64, 1'b0, 1'b1, RM_RUP, 1'b0);
  add_vec("single_fmadd_s", EXT_SINGLE, enc_r4(OPC_MADD, 2'b00, 3'b000), 2'b11,
          OP_FMADD, 1'b0, FMT_FP32, 1'b0, 1'b0, RM_RNE, 1'b0);
  add_vec("single_unknown_funct7", EXT_SINGLE, enc_op(7'b0011000, 5'd0, 3'b000), 2'b00,
          OP_FMADD, 1'b0, FMT_FP32, 1'b0, 1'b1, RM_RNE, 1'b0);
  add_vec("none_fadd_s", EXT_NONE, enc_op(7'b0000000, 5'd0, 3'b000), 2'b01,
          OP_FMADD, 1'b0, FMT_FP32, 1'b0, 1'b1, RM_RNE, 1'b0);
  add_vec("none_flw", EXT_NONE, enc_mem(OPC_LOAD_FP, 3'b010), 2'b01,
          OP_FMADD, 1'b0, FMT_FP32, 1'b0, 1'b1, RM_RDN, 1'b0);
  add_vec("unknown_opcode", EXT_DOUBLE, 32'h0000_0033, 2'b00,
          OP_FMADD, 1'b0, FMT_FP32, 1'b0, 1'b1, RM_RNE, 1'b0);
  add_vec("unknown_funct7", EXT_DOUBLE, enc_op(7'b0011000, 5'd0, 3'b000), 2'b00,
          OP_FMADD, 1'b0, FMT_FP32, 1'b0, 1'b1, RM_RNE, 1'b0);
endtask

`endif

//--- testbench/tb_fp_decoder.sv
`timescale 1ns/10ps
`include "fp_dec_defines.svh"

module tb_fp_decoder;

  import fp_dec_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int DEPTH      = `FP_DEC_DEPTH;
  localparam int OUT_CRED   = `FP_DEC_OUT_CREDITS;

  logic        clk;
  logic        rst_n;
  logic        cfg_we;
  fp_ext_e     cfg_ext;
  logic        in_valid;
  logic [31:0] instr;
  logic        out_credit;
  logic        in_credit_o;
  logic        out_valid_o;
  logic [4:0]  rs1_o;
  logic [4:0]  rs2_o;
  logic [4:0]  rs3_o;
  logic [4:0]  rd_o;
  fp_rm_e      rm_o;
  logic        rm_dynamic_o;
  fp_operation_e operation_o;
  logic        op_mod_o;
  fp_format_e  src_fmt_o;
  logic        load_o;
  logic        illegal_o;

  // stimulus table columns
  string         v_name[$];
  fp_ext_e       v_ext[$];
  logic [31:0]   v_word[$];
  logic [1:0]    v_rmask[$];
  fp_operation_e v_op[$];
  logic          v_mod[$];
  fp_format_e    v_fmt[$];
  logic          v_load[$];
  logic          v_ill[$];
  fp_rm_e        v_rm[$];
  logic          v_dyn[$];

  // model FIFO of outstanding instructions
  int          exp_idx[$];
  logic [31:0] exp_word[$];
  int          exp_cycle[$];

  int errors;
  int tests_failed;
  int results;
  int cycle;
  int fetch_credits;
  int issue_credits;
  int credit_pulses;
  bit test_bad;
  bit loaded;

  fp_decoder_top fp_decoder_top_inst (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .cfg_we_i     (cfg_we),
    .cfg_ext_i    (cfg_ext),
    .in_valid_i   (in_valid),
    .instr_i      (instr),
    .out_credit_i (out_credit),
    .in_credit_o  (in_credit_o),
    .out_valid_o  (out_valid_o),
    .rs1_o        (rs1_o),
    .rs2_o        (rs2_o),
    .rs3_o        (rs3_o),
    .rd_o         (rd_o),
    .rm_o         (rm_o),
    .rm_dynamic_o (rm_dynamic_o),
    .operation_o  (operation_o),
    .op_mod_o     (op_mod_o),
    .src_fmt_o    (src_fmt_o),
    .load_o       (load_o),
    .illegal_o    (illegal_o)
  );

  ////////////////////////////////////////
  // encoders and table fill
  ////////////////////////////////////////

  function automatic logic [31:0] enc_op(logic [6:0] f7, logic [4:0] rs2, logic [2:0] f3);
    return {f7, rs2, 5'd0, f3, 5'd0, 7'b1010011};
  endfunction

  function automatic logic [31:0] enc_r4(fp_opcode_e opc, logic [1:0] fmt, logic [2:0] rm);
    return {5'd0, fmt, 5'd0, 5'd0, rm, 5'd0, 7'(opc)};
  endfunction

  function automatic logic [31:0] enc_mem(fp_opcode_e opc, logic [2:0] f3);
    return {12'd0, 5'd0, f3, 5'd0, 7'(opc)};
  endfunction

  task automatic add_vec(string nm, fp_ext_e ext, logic [31:0] word, logic [1:0] rmask,
                         fp_operation_e op, logic md, fp_format_e fmt, logic ld,
                         logic ill, fp_rm_e rm, logic dyn);
    v_name.push_back(nm);
    v_ext.push_back(ext);
    v_word.push_back(word);
    v_rmask.push_back(rmask);
    v_op.push_back(op);
    v_mod.push_back(md);
    v_fmt.push_back(fmt);
    v_load.push_back(ld);
    v_ill.push_back(ill);
    v_rm.push_back(rm);
    v_dyn.push_back(dyn);
  endtask

  `include "tb_fp_vectors.svh"

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////

  task automatic check_op(string tn, fp_operation_e exp, fp_operation_e act);
    if (act !== exp) begin
      $display("ERR %s operation expected %s actual %s", tn, exp.name(), act.name());
      errors++;
      test_bad = 1'b1;
    end
  endtask

  task automatic check_fmt(string tn, fp_format_e exp, fp_format_e act);
    if (act !== exp) begin
      $display("ERR %s format expected %s actual %s", tn, exp.name(), act.name());
      errors++;
      test_bad = 1'b1;
    end
  endtask

  task automatic check_rm(string tn, fp_rm_e exp, fp_rm_e act);
    if (act !== exp) begin
      $display("ERR %s rm expected %0d actual %0d", tn, exp, act);
      errors++;
      test_bad = 1'b1;
    end
  endtask

  task automatic check_bit(string tn, string field, logic exp, logic act);
    if (act !== exp) begin
      $display("ERR %s %s expected %b actual %b", tn, field, exp, act);
      errors++;
      test_bad = 1'b1;
    end
  endtask

  task automatic check_reg(string tn, string field, logic [4:0] exp, logic [4:0] act);
    if (act !== exp) begin
      $display("ERR %s %s expected %0d actual %0d", tn, field, exp, act);
      errors++;
      test_bad = 1'b1;
    end
  endtask

  // pop one expected entry and compare it with the queue head
  task automatic check_result();
    int          idx;
    int          sent;
    logic [31:0] w;
    string       tn;
    test_bad = 1'b0;
    if (issue_credits == 0) begin
      $display("out_valid_o went high while issue held every credit");
      errors++;
    end else begin
      issue_credits--;
    end
    if (exp_idx.size() == 0) begin
      $display("a result came out with no instruction outstanding");
      errors++;
      return;
    end
    idx  = exp_idx.pop_front();
    w    = exp_word.pop_front();
    sent = exp_cycle.pop_front();
    tn   = v_name[idx];
    // first instruction meets an empty, credited queue
    if (idx == 0 && cycle != sent + 1) begin
      $display("%s arrived %0d cycles after acceptance instead of 1", tn, cycle - sent);
      errors++;
      test_bad = 1'b1;
    end
    check_reg(tn, "rs1", w[19:15], rs1_o);
    check_reg(tn, "rs2", w[24:20], rs2_o);
    check_reg(tn, "rs3", w[31:27], rs3_o);
    check_reg(tn, "rd", w[11:7], rd_o);
    check_rm(tn, v_rm[idx], rm_o);
    check_bit(tn, "rm_dynamic", v_dyn[idx], rm_dynamic_o);
    check_op(tn, v_op[idx], operation_o);
    check_bit(tn, "op_mod", v_mod[idx], op_mod_o);
    check_bit(tn, "load", v_load[idx], load_o);
    check_bit(tn, "illegal", v_ill[idx], illegal_o);
    if (!v_ill[idx]) begin
      check_fmt(tn, v_fmt[idx], src_fmt_o);
    end
    results++;
    if (test_bad) begin
      tests_failed++;
      $display("test %s FAIL", tn);
    end else begin
      $display("test %s ok", tn);
    end
  endtask

  ////////////////////////////////////////
  // clock, cycle step, watchdog
  ////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // sample at the falling edge, then drive the next cycle's inputs
  task automatic tick();
    @(negedge clk);
    cycle++;
    if (in_credit_o) begin
      credit_pulses++;
      fetch_credits++;
    end
    if (out_valid_o) begin
      check_result();
    end
    in_valid   = 1'b0;
    cfg_we     = 1'b0;
    out_credit = 1'b0;
    // issue hands back a spent credit now and then
    if (issue_credits < OUT_CRED && ($urandom() % 3) == 0) begin
      out_credit = 1'b1;
      issue_credits++;
    end
  endtask

  initial begin
    wait (loaded);
    #(v_name.size() * 20 * CLK_PERIOD);
    $display("watchdog expired, the decoder stopped delivering results");
    $display("Test failed");
    $finish;
  end

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    logic [31:0] w;
    void'($urandom(32'h809a));
    rst_n      = 1'b0;
    cfg_we     = 1'b0;
    cfg_ext    = EXT_DOUBLE;
    in_valid   = 1'b0;
    instr      = '0;
    out_credit = 1'b0;
    errors        = 0;
    tests_failed  = 0;
    results       = 0;
    cycle         = 0;
    credit_pulses = 0;
    fetch_credits = DEPTH;
    issue_credits = OUT_CRED;
    load_vectors();
    loaded = 1'b1;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    tick();
    check_bit("reset", "out_valid_o", 1'b0, out_valid_o);
    check_bit("reset", "in_credit_o", 1'b0, in_credit_o);
    for (int i = 0; i < v_name.size(); i++) begin
      cfg_ext = v_ext[i];
      cfg_we  = 1'b1;
      tick();
      while (fetch_credits == 0) begin
        tick();
      end
      w = v_word[i];
      w[19:15] = 5'($urandom());
      w[11:7]  = 5'($urandom());
      if (v_rmask[i][0]) begin
        w[24:20] = 5'($urandom());
      end
      if (v_rmask[i][1]) begin
        w[31:27] = 5'($urandom());
      end
      instr    = w;
      in_valid = 1'b1;
      fetch_credits--;
      exp_idx.push_back(i);
      exp_word.push_back(w);
      exp_cycle.push_back(cycle);
    end
    // drain queue, then idle so late or extra credit pulses show up
    tick();
    while (exp_idx.size() > 0) begin
      tick();
    end
    repeat (DEPTH) begin
      tick();
    end
    if (credit_pulses != results) begin
      $display("counts disagree, %0d sent, %0d results, %0d credit pulses",
               v_name.size(), results, credit_pulses);
      errors++;
    end
    $display("%0d tests, %0d failed, %0d errors", results, tests_failed, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- logic/fp_decoder_top.sv
`timescale 1ns/10ps
`include "fp_dec_defines.svh"

module fp_decoder_top (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          cfg_we_i,
  input  fp_dec_pkg::fp_ext_e           cfg_ext_i,
  input  logic                          in_valid_i,
  input  logic [`FP_DEC_ILEN-1:0]       instr_i,
  input  logic                          out_credit_i,
  output logic                          in_credit_o,
  output logic                          out_valid_o,
  // decoded results, valid with out_valid_o
  output logic [`FP_DEC_REG_W-1:0]      rs1_o,
  output logic [`FP_DEC_REG_W-1:0]      rs2_o,
  output logic [`FP_DEC_REG_W-1:0]      rs3_o,
  output logic [`FP_DEC_REG_W-1:0]      rd_o,
  output fp_dec_pkg::fp_rm_e            rm_o,
  output logic                          rm_dynamic_o,
  output fp_dec_pkg::fp_operation_e     operation_o,
  output logic                          op_mod_o,
  output fp_dec_pkg::fp_format_e        src_fmt_o,
  output logic                          load_o,
  output logic                          illegal_o
);

  import fp_dec_pkg::*;

  fp_ext_e       ext;
  // classify result and queue head
  fp_dec_entry_t dec_entry;
  fp_dec_entry_t head_entry;

  fp_ext_cfg fp_ext_cfg_inst (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .cfg_we_i  (cfg_we_i),
    .cfg_ext_i (cfg_ext_i),
    .ext_o     (ext)
  );

  fp_insn_classify fp_insn_classify_inst (
    .instr_i (instr_i),
    .ext_i   (ext),
    .entry_o (dec_entry)
  );

  fp_decode_stage fp_decode_stage_inst (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .in_valid_i   (in_valid_i),
    .entry_i      (dec_entry),
    .out_credit_i (out_credit_i),
    .entry_o      (head_entry),
    .out_valid_o  (out_valid_o),
    .in_credit_o  (in_credit_o)
  );

  // unpack the queue head onto the result ports
  assign rs1_o        = head_entry.rs1;
  assign rs2_o        = head_entry.rs2;
  assign rs3_o        = head_entry.rs3;
  assign rd_o         = head_entry.rd;
  assign rm_o         = head_entry.rm;
  assign rm_dynamic_o = head_entry.rm_dynamic;
  assign operation_o  = head_entry.operation;
  assign op_mod_o     = head_entry.op_mod;
  assign src_fmt_o    = head_entry.src_fmt;
  assign load_o       = head_entry.load;
  assign illegal_o    = head_entry.illegal;

endmodule

//--- logic/fp_decode_stage.sv
`timescale 1ns/10ps
`include "fp_dec_defines.svh"

module fp_decode_stage (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      in_valid_i,
  input  fp_dec_pkg::fp_dec_entry_t entry_i,
  input  logic                      out_credit_i,
  output fp_dec_pkg::fp_dec_entry_t entry_o,
  output logic                      out_valid_o,
  output logic                      in_credit_o
);

  import fp_dec_pkg::*;

  localparam int DEPTH  = `FP_DEC_DEPTH;
  localparam int PTR_W  = $clog2(DEPTH);
  localparam int CRED_W = `FP_DEC_CRED_W;
  localparam logic [CRED_W-1:0] CRED_MAX = CRED_W'(`FP_DEC_OUT_CREDITS);
  localparam logic [PTR_W-1:0]  PTR_LAST = PTR_W'(DEPTH - 1);

  fp_dec_entry_t     mem_q [DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [PTR_W:0]    fill_q;
  logic [CRED_W-1:0] credits_q;
  logic              in_credit_q;
  logic              empty;
  logic              full;
  logic              pop;

  assign empty = (fill_q == '0);
  assign full  = (fill_q == (PTR_W + 1)'(DEPTH));
  // a transfer happens whenever an entry and a credit are both present
  assign pop   = !empty && (credits_q != '0);

  // payload storage
  always_ff @(posedge clk_i) begin
    if (in_valid_i) begin
      mem_q[wr_ptr_q] <= entry_i;
    end
  end

  ////////////////////////////////////////
  // pointers, fill and credits
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      fill_q      <= '0;
      credits_q   <= CRED_MAX;
      in_credit_q <= 1'b0;
    end else begin
      if (in_valid_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({in_valid_i, pop})
        2'b10:   fill_q <= fill_q + 1'b1;
        2'b01:   fill_q <= fill_q - 1'b1;
        default: fill_q <= fill_q;
      endcase
      // issue returns one, each transfer spends one
      case ({out_credit_i, pop})
        2'b10:   credits_q <= credits_q + 1'b1;
        2'b01:   credits_q <= credits_q - 1'b1;
        default: credits_q <= credits_q;
      endcase
      // freed slot goes back to fetch a cycle later
      in_credit_q <= pop;
    end
  end

  assign entry_o     = mem_q[rd_ptr_q];
  assign out_valid_o = pop;
  assign in_credit_o = in_credit_q;

  // fetch must hold back once its credits are gone
  a_no_write_full : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    in_valid_i |-> !full)
    else $error("write into a full decode queue");

  // issue never returns more than it was given
  a_credit_max : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    credits_q <= CRED_MAX)
    else $error("output credit count above its limit");

endmodule

//--- logic/fp_insn_classify.sv
`timescale 1ns/10ps
`include "fp_dec_defines.svh"

module fp_insn_classify (
  input  logic [`FP_DEC_ILEN-1:0] instr_i,
  input  fp_dec_pkg::fp_ext_e     ext_i,
  output fp_dec_pkg::fp_dec_entry_t entry_o
);

  import fp_dec_pkg::*;

  fp_opcode_e               opcode;
  logic [6:0]               funct7;
  logic [`FP_DEC_RM_W-1:0]  funct3;
  logic [`FP_DEC_REG_W-1:0] rs2_field;
  // reserved rounding modes 101 and 110
  logic                     rm_bad;
  fp_operation_e            op;
  logic                     op_mod;
  fp_format_e               fmt;
  logic                     is_load;
  // encoding found in the decode table
  logic                     listed;
  // funct3 is a rounding mode for this op
  logic                     uses_rm;
  logic                     fmt_ok;
  logic                     illegal;

  assign opcode    = fp_opcode_e'(instr_i[6:0]);
  assign funct7    = instr_i[31:25];
  assign funct3    = instr_i[14:12];
  assign rs2_field = instr_i[24:20];
  assign rm_bad    = (funct3 == 3'b101) || (funct3 == 3'b110);

  ////////////////////////////////////////
  // decode table
  ////////////////////////////////////////

  always_comb begin
    op      = OP_FMADD;
    op_mod  = 1'b0;
    fmt     = FMT_FP32;
    is_load = 1'b0;
    listed  = 1'b0;
    uses_rm = 1'b0;
    case (opcode)
      OPC_LOAD_FP, OPC_STORE_FP: begin
        // flw/fsw 010, fld/fsd 011
        is_load = (opcode == OPC_LOAD_FP);
        listed  = (funct3 == 3'b010) || (funct3 == 3'b011);
        fmt     = fp_format_e'(funct3[0]);
      end
      OPC_MADD, OPC_MSUB, OPC_NMSUB, OPC_NMADD: begin
        // msub and nmadd are the negated-addend variants
        op      = ((opcode == OPC_MADD) || (opcode == OPC_MSUB)) ? OP_FMADD : OP_FNMSUB;
        op_mod  = (opcode == OPC_MSUB) || (opcode == OPC_NMADD);
        fmt     = fp_format_e'(instr_i[25]);
        listed  = ~instr_i[26];
        uses_rm = 1'b1;
      end
      OPC_OP_FP: begin
        // funct7 bit 0 is the format, the rest selects the op
        fmt = fp_format_e'(funct7[0]);
        case (funct7[6:1])
          6'b000000: begin
            op      = OP_ADD;
            listed  = 1'b1;
            uses_rm = 1'b1;
          end
          // fsub
          6'b000010: begin
            op      = OP_ADD;
            op_mod  = 1'b1;
            listed  = 1'b1;
            uses_rm = 1'b1;
          end
          6'b000100: begin
            op      = OP_MUL;
            listed  = 1'b1;
            uses_rm = 1'b1;
          end
          6'b000110: begin
            op      = OP_DIV;
            listed  = 1'b1;
            uses_rm = 1'b1;
          end
          6'b010110: begin
            op      = OP_SQRT;
            listed  = (rs2_field == '0);
            uses_rm = 1'b1;
          end
          // fsgnj, fsgnjn, fsgnjx
          6'b001000: begin
            op     = OP_SGNJ;
            listed = (funct3 == 3'b000) || (funct3 == 3'b001) || (funct3 == 3'b010);
          end
          // fmin, fmax
          6'b001010: begin
            op     = OP_MINMAX;
            listed = (funct3 == 3'b000) || (funct3 == 3'b001);
          end
          // fle, flt, feq
          6'b101000: begin
            op     = OP_CMP;
            listed = (funct3 == 3'b000) || (funct3 == 3'b001) || (funct3 == 3'b010);
          end
          // fcvt.s.d takes rs2 00001, fcvt.d.s takes 00000
          // both directions need D, so the format is fp64
          6'b010000: begin
            op      = OP_F2F;
            fmt     = FMT_FP64;
            listed  = (rs2_field == {4'b0000, ~funct7[0]});
            uses_rm = 1'b1;
          end
          // fcvt.w[u].s / .d, rs2 bit 0 picks unsigned
          6'b110000: begin
            op      = OP_F2I;
            op_mod  = rs2_field[0];
            listed  = (rs2_field[4:1] == '0);
            uses_rm = 1'b1;
          end
          // fcvt.s / .d.w[u]
          6'b110100: begin
            op      = OP_I2F;
            op_mod  = rs2_field[0];
            listed  = (rs2_field[4:1] == '0);
            uses_rm = 1'b1;
          end
          // fclass, or fmv.x.w on the fp32 side
          6'b111000: begin
            if ((rs2_field == '0) && (funct3 == 3'b001)) begin
              op     = OP_CLASSIFY;
              listed = 1'b1;
            end else if ((rs2_field == '0) && (funct3 == 3'b000) && !funct7[0]) begin
              op     = OP_ADD;
              listed = 1'b1;
            end
          end
          // fmv.w.x, fp32 only
          6'b111100: begin
            op     = OP_ADD;
            listed = (rs2_field == '0) && (funct3 == 3'b000) && !funct7[0];
          end
          default: begin
            listed = 1'b0;
          end
        endcase
      end
      default: begin
        listed = 1'b0;
      end
    endcase
  end

  ////////////////////////////////////////
  // legality and result
  ////////////////////////////////////////

  // none rejects all, single rejects fp64
  assign fmt_ok  = (ext_i == EXT_DOUBLE) || ((ext_i == EXT_SINGLE) && (fmt == FMT_FP32));
  assign illegal = !listed || !fmt_ok || (uses_rm && rm_bad);

  // register fields pass straight through
  assign entry_o.rs1        = instr_i[19:15];
  assign entry_o.rs2        = rs2_field;
  assign entry_o.rs3        = instr_i[31:27];
  assign entry_o.rd         = instr_i[11:7];
  assign entry_o.rm         = fp_rm_e'(funct3);
  assign entry_o.rm_dynamic = (funct3 == 3'b111);
  assign entry_o.src_fmt    = fmt;
  assign entry_o.illegal    = illegal;
  // illegal words carry a neutral op
  assign entry_o.operation  = illegal ? OP_FMADD : op;
  assign entry_o.op_mod     = illegal ? 1'b0 : op_mod;
  assign entry_o.load       = illegal ? 1'b0 : is_load;

endmodule

//--- logic/fp_ext_cfg.sv
`timescale 1ns/10ps
`include "fp_dec_defines.svh"

module fp_ext_cfg (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                cfg_we_i,
  input  fp_dec_pkg::fp_ext_e cfg_ext_i,
  output fp_dec_pkg::fp_ext_e ext_o
);

  import fp_dec_pkg::*;

  fp_ext_e ext_q;
  logic    wr_legal;

  // only the three defined levels are accepted
  assign wr_legal = (cfg_ext_i == EXT_NONE) || (cfg_ext_i == EXT_SINGLE) ||
                    (cfg_ext_i == EXT_DOUBLE);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ext_q <= `FP_DEC_RESET_EXT;
    end else if (cfg_we_i && wr_legal) begin
      ext_q <= cfg_ext_i;
    end
  end

  // level seen by the decoder from the next cycle on
  assign ext_o = ext_q;

  // decode logic relies on one of the three known levels
  a_ext_legal : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ext_o inside {EXT_NONE, EXT_SINGLE, EXT_DOUBLE})
    else $error("extension level left the defined set");

endmodule

//--- logic/fp_dec_pkg.sv
`include "fp_dec_defines.svh"

package fp_dec_pkg;

  // major opcodes of the F and D extensions
  typedef enum logic [6:0] {
    OPC_LOAD_FP  = 7'b0000111,
    OPC_STORE_FP = 7'b0100111,
    OPC_MADD     = 7'b1000011,
    OPC_MSUB     = 7'b1000111,
    OPC_NMSUB    = 7'b1001011,
    OPC_NMADD    = 7'b1001111,
    OPC_OP_FP    = 7'b1010011
  } fp_opcode_e;

  // fpu operation groups
  typedef enum logic [3:0] {
    OP_FMADD, OP_FNMSUB, OP_ADD, OP_MUL, OP_DIV, OP_SQRT, OP_SGNJ,
    OP_MINMAX, OP_CMP, OP_CLASSIFY, OP_F2F, OP_F2I, OP_I2F
  } fp_operation_e;

  typedef enum logic {FMT_FP32, FMT_FP64} fp_format_e;

  // supported extension level
  typedef enum logic [1:0] {
    EXT_NONE   = 2'd0,
    EXT_SINGLE = 2'd1,
    EXT_DOUBLE = 2'd2
  } fp_ext_e;

  // 101 and 110 are reserved
  typedef enum logic [`FP_DEC_RM_W-1:0] {
    RM_RNE = 3'b000,
    RM_RTZ = 3'b001,
    RM_RDN = 3'b010,
    RM_RUP = 3'b011,
    RM_RMM = 3'b100,
    RM_DYN = 3'b111
  } fp_rm_e;

  // one decoded instruction as held in the queue
  typedef struct packed {
    logic [`FP_DEC_REG_W-1:0] rs1;
    logic [`FP_DEC_REG_W-1:0] rs2;
    logic [`FP_DEC_REG_W-1:0] rs3;
    logic [`FP_DEC_REG_W-1:0] rd;
    fp_rm_e                   rm;
    logic                     rm_dynamic;
    fp_operation_e            operation;
    logic                     op_mod;
    fp_format_e               src_fmt;
    logic                     load;
    logic                     illegal;
  } fp_dec_entry_t;

endpackage

//--- logic/fp_dec_defines.svh
`ifndef FP_DEC_DEFINES_SVH
`define FP_DEC_DEFINES_SVH

////////////////////////////////////////
// instruction fields
////////////////////////////////////////

// instruction word width
`define FP_DEC_ILEN 32
// fp register index width
`define FP_DEC_REG_W 5
// rounding mode field width, funct3
`define FP_DEC_RM_W 3

////////////////////////////////////////
// queue and flow control
////////////////////////////////////////

// decode queue entries, also the credits fetch starts with
`define FP_DEC_DEPTH 4
// credits held toward issue after reset
`define FP_DEC_OUT_CREDITS 2
// credit counter width
`define FP_DEC_CRED_W 3

// extension level out of reset, F and D
`define FP_DEC_RESET_EXT fp_dec_pkg::EXT_DOUBLE

`endif
